//--- Makefile
VERILATOR ?= verilator
TOP       ?= xfcp_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/wb_ram.sv
// Word RAM on a simple bus port
// 256 x 32 bit, whole-word writes, ack one cycle after strobe

module wb_ram import xfcp_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_n_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    localparam int DEPTH = 2 ** WB_ADDR_W;

    logic [WB_DATA_W-1:0] mem [DEPTH];
    logic [WB_DATA_W-1:0] rd_q;
    logic                 ack_q;

    always_ff @(posedge clk_i) begin
        if (req_i.stb && req_i.we && !ack_q) begin
            mem[req_i.adr] <= req_i.dat;
        end
        rd_q <= mem[req_i.adr];
    end

    // Masked by ack so a held strobe is answered only once
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_i.stb && !ack_q;
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;

endmodule

//--- design/xfcp_pkg.sv
// XFCP RAM hub shared definitions
// Stream beat, bus request/response types and protocol constants

package xfcp_pkg;

    localparam int XFCP_N_PORTS   = 4;
    localparam int PORT_W         = $clog2(XFCP_N_PORTS);
    localparam int WB_ADDR_W      = 8;
    localparam int WB_DATA_W      = 32;
    localparam int BYTES_PER_WORD = 4;

    // Command and response opcodes
    localparam logic [7:0] OP_READ       = 8'h10;
    localparam logic [7:0] OP_READ_RESP  = 8'h11;
    localparam logic [7:0] OP_WRITE      = 8'h12;
    localparam logic [7:0] OP_WRITE_RESP = 8'h13;

    // One byte of a command or response packet
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } xfcp_beat_t;

    // stb covers cyc and stb of the usual bus
    typedef struct packed {
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
        logic                 we;
        logic                 stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DATA_W-1:0] dat;
        logic                 ack;
    } wb_rsp_t;

endpackage

//--- design/xfcp_port_demux.sv
// XFCP port demux
// Steers each command packet to the endpoint named by its first byte.
// Packets for a port that does not exist are swallowed up to last.

module xfcp_port_demux import xfcp_pkg::*; (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  xfcp_beat_t                        cmd_i,
    input  logic                              cmd_valid_i,
    output logic                              cmd_ready_o,

    output xfcp_beat_t [XFCP_N_PORTS-1:0]     port_cmd_o,
    output logic       [XFCP_N_PORTS-1:0]     port_cmd_valid_o,
    input  logic       [XFCP_N_PORTS-1:0]     port_cmd_ready_i
);

    logic              active_q;
    logic              drop_q;
    logic [PORT_W-1:0] dest_q;
    logic              cmd_fire;

    assign cmd_fire = cmd_valid_i && cmd_ready_o;

    // Route is taken from the first beat while it waits, then held to last
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
        end else if (!active_q) begin
            if (cmd_valid_i) begin
                active_q <= 1'b1;
                dest_q   <= cmd_i.data[PORT_W-1:0];
                drop_q   <= cmd_i.data >= 8'(XFCP_N_PORTS);
            end
        end else if (cmd_fire && cmd_i.last) begin
            active_q <= 1'b0;
        end
    end

    always_comb begin
        cmd_ready_o = 1'b0;
        if (active_q) begin
            cmd_ready_o = drop_q ? 1'b1 : port_cmd_ready_i[dest_q];
        end

        for (int i = 0; i < XFCP_N_PORTS; i++) begin
            port_cmd_o[i]       = cmd_i;
            port_cmd_valid_o[i] = active_q && !drop_q && cmd_valid_i &&
                                  (dest_q == PORT_W'(i));
        end
    end

endmodule

//--- design/xfcp_ram_endpoint.sv
// XFCP memory endpoint
// Parses read and write commands, runs one bus cycle per word on the
// attached RAM and streams the response packet back out

module xfcp_ram_endpoint import xfcp_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  xfcp_beat_t cmd_i,
    input  logic       cmd_valid_i,
    output logic       cmd_ready_o,

    output xfcp_beat_t resp_o,
    output logic       resp_valid_o,
    input  logic       resp_ready_i,

    output wb_req_t    wb_req_o,
    input  wb_rsp_t    wb_rsp_i
);

    typedef enum logic [2:0] {
        ST_HDR,
        ST_WR_DATA,
        ST_WR_BUS,
        ST_DRAIN,
        ST_RESP_HDR,
        ST_RD_BUS,
        ST_RD_DATA
    } state_t;

    state_t               state;
    logic [1:0]           hdr_idx;
    logic [1:0]           byte_idx;
    logic [7:0]           port_q;
    logic [7:0]           op_q;
    logic [7:0]           addr_q;
    logic [7:0]           count_q;
    logic [7:0]           words_left;
    logic [WB_ADDR_W-1:0] adr_q;
    logic [WB_DATA_W-1:0] word_q;
    logic                 pkt_done;
    logic                 send_resp;
    logic                 is_write;
    logic                 cmd_fire;
    logic                 resp_fire;

    assign is_write  = (op_q == OP_WRITE);
    assign cmd_fire  = cmd_valid_i && cmd_ready_o;
    assign resp_fire = resp_valid_o && resp_ready_i;

    assign cmd_ready_o  = (state == ST_HDR) || (state == ST_WR_DATA) || (state == ST_DRAIN);
    assign resp_valid_o = (state == ST_RESP_HDR) || (state == ST_RD_DATA);

    assign wb_req_o.adr = adr_q;
    assign wb_req_o.dat = word_q;
    assign wb_req_o.we  = (state == ST_WR_BUS);
    assign wb_req_o.stb = (state == ST_WR_BUS) || (state == ST_RD_BUS);

    always_comb begin
        resp_o.data = word_q[7:0];
        resp_o.last = (byte_idx == 2'd3) && (words_left == 8'd1);
        if (state == ST_RESP_HDR) begin
            case (hdr_idx)
                2'd0:    resp_o.data = port_q;
                2'd1:    resp_o.data = is_write ? OP_WRITE_RESP : OP_READ_RESP;
                2'd2:    resp_o.data = addr_q;
                default: resp_o.data = count_q;
            endcase
            resp_o.last = (hdr_idx == 2'd3) && (is_write || count_q == 8'd0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state    <= ST_HDR;
            hdr_idx  <= 2'd0;
            byte_idx <= 2'd0;
        end else begin
            case (state)
                ST_HDR: if (cmd_fire) begin
                    byte_idx <= 2'd0;
                    hdr_idx  <= hdr_idx + 2'd1;
                    case (hdr_idx)
                        2'd0: port_q <= cmd_i.data;
                        2'd1: op_q   <= cmd_i.data;
                        2'd2: begin
                            addr_q <= cmd_i.data;
                            adr_q  <= cmd_i.data;
                        end
                        default: begin
                            count_q    <= cmd_i.data;
                            words_left <= cmd_i.data;
                        end
                    endcase
                    if (hdr_idx == 2'd3) begin
                        send_resp <= (op_q == OP_READ) || is_write;
                        if (is_write && cmd_i.data != 8'd0 && !cmd_i.last) begin
                            state <= ST_WR_DATA;
                        end else if (op_q == OP_READ || is_write) begin
                            state <= cmd_i.last ? ST_RESP_HDR : ST_DRAIN;
                        end else if (!cmd_i.last) begin
                            state <= ST_DRAIN;
                        end
                    end else if (cmd_i.last) begin
                        // Short header gets no answer
                        hdr_idx <= 2'd0;
                    end
                end
                ST_WR_DATA: if (cmd_fire) begin
                    word_q   <= {cmd_i.data, word_q[WB_DATA_W-1:8]};
                    byte_idx <= byte_idx + 2'd1;
                    pkt_done <= cmd_i.last;
                    if (byte_idx == 2'd3) begin
                        state <= ST_WR_BUS;
                    end else if (cmd_i.last) begin
                        state <= ST_RESP_HDR;
                    end
                end
                ST_WR_BUS: if (wb_rsp_i.ack) begin
                    adr_q      <= adr_q + WB_ADDR_W'(1);
                    words_left <= words_left - 8'd1;
                    if (pkt_done) begin
                        state <= ST_RESP_HDR;
                    end else if (words_left == 8'd1) begin
                        state <= ST_DRAIN;
                    end else begin
                        state <= ST_WR_DATA;
                    end
                end
                ST_DRAIN: if (cmd_fire && cmd_i.last) begin
                    state <= send_resp ? ST_RESP_HDR : ST_HDR;
                end
                ST_RESP_HDR: if (resp_fire) begin
                    hdr_idx <= hdr_idx + 2'd1;
                    if (hdr_idx == 2'd3) begin
                        state <= (!is_write && count_q != 8'd0) ? ST_RD_BUS : ST_HDR;
                    end
                end
                ST_RD_BUS: if (wb_rsp_i.ack) begin
                    word_q <= wb_rsp_i.dat;
                    adr_q  <= adr_q + WB_ADDR_W'(1);
                    state  <= ST_RD_DATA;
                end
                ST_RD_DATA: if (resp_fire) begin
                    // Least significant byte goes out first
                    word_q   <= word_q >> 8;
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_idx == 2'd3) begin
                        words_left <= words_left - 8'd1;
                        state      <= (words_left == 8'd1) ? ST_HDR : ST_RD_BUS;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

//--- design/xfcp_ram_hub.sv
// XFCP RAM hub top level
// One host command stream fanned out to four RAM endpoints,
// responses merged back into one host stream

module xfcp_ram_hub import xfcp_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  xfcp_beat_t host_in_i,
    input  logic       host_in_valid_i,
    output logic       host_in_ready_o,

    output xfcp_beat_t host_out_o,
    output logic       host_out_valid_o,
    input  logic       host_out_ready_i
);

    xfcp_beat_t [XFCP_N_PORTS-1:0] cmd_beat;
    logic       [XFCP_N_PORTS-1:0] cmd_valid;
    logic       [XFCP_N_PORTS-1:0] cmd_ready;
    xfcp_beat_t [XFCP_N_PORTS-1:0] resp_beat;
    logic       [XFCP_N_PORTS-1:0] resp_valid;
    logic       [XFCP_N_PORTS-1:0] resp_ready;

    xfcp_port_demux u_demux (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .cmd_i            (host_in_i),
        .cmd_valid_i      (host_in_valid_i),
        .cmd_ready_o      (host_in_ready_o),
        .port_cmd_o       (cmd_beat),
        .port_cmd_valid_o (cmd_valid),
        .port_cmd_ready_i (cmd_ready)
    );

    for (genvar p = 0; p < XFCP_N_PORTS; p++) begin : g_port
        wb_req_t wb_req;
        wb_rsp_t wb_rsp;

        xfcp_ram_endpoint u_endpoint (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .cmd_i        (cmd_beat[p]),
            .cmd_valid_i  (cmd_valid[p]),
            .cmd_ready_o  (cmd_ready[p]),
            .resp_o       (resp_beat[p]),
            .resp_valid_o (resp_valid[p]),
            .resp_ready_i (resp_ready[p]),
            .wb_req_o     (wb_req),
            .wb_rsp_i     (wb_rsp)
        );

        wb_ram u_ram (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (wb_req),
            .rsp_o   (wb_rsp)
        );
    end

    xfcp_resp_arbiter u_arbiter (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .port_resp_i       (resp_beat),
        .port_resp_valid_i (resp_valid),
        .port_resp_ready_o (resp_ready),
        .resp_o            (host_out_o),
        .resp_valid_o      (host_out_valid_o),
        .resp_ready_i      (host_out_ready_i)
    );

endmodule

//--- design/xfcp_resp_arbiter.sv
// XFCP response arbiter
// Round-robin merge of endpoint response streams into one host stream,
// a whole packet at a time

module xfcp_resp_arbiter import xfcp_pkg::*; (
    input  logic                              clk_i,
    input  logic                              rst_n_i,

    input  xfcp_beat_t [XFCP_N_PORTS-1:0]     port_resp_i,
    input  logic       [XFCP_N_PORTS-1:0]     port_resp_valid_i,
    output logic       [XFCP_N_PORTS-1:0]     port_resp_ready_o,

    output xfcp_beat_t                        resp_o,
    output logic                              resp_valid_o,
    input  logic                              resp_ready_i
);

    logic [PORT_W-1:0] rr_q;
    logic [PORT_W-1:0] grant_q;
    logic [PORT_W-1:0] pick;
    logic [PORT_W-1:0] idx;
    logic              locked_q;
    logic              found;

    // First requester at or after the round-robin pointer
    always_comb begin
        pick  = rr_q;
        found = 1'b0;
        idx   = rr_q;
        for (int k = 0; k < XFCP_N_PORTS; k++) begin
            idx = PORT_W'((int'(rr_q) + k) % XFCP_N_PORTS);
            if (!found && port_resp_valid_i[idx]) begin
                pick  = idx;
                found = 1'b1;
            end
        end
    end

    assign resp_o       = port_resp_i[grant_q];
    assign resp_valid_o = locked_q && port_resp_valid_i[grant_q];

    always_comb begin
        for (int i = 0; i < XFCP_N_PORTS; i++) begin
            port_resp_ready_o[i] = locked_q && resp_ready_i && (grant_q == PORT_W'(i));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            locked_q <= 1'b0;
            grant_q  <= '0;
            rr_q     <= '0;
        end else if (!locked_q) begin
            if (found) begin
                locked_q <= 1'b1;
                grant_q  <= pick;
            end
        end else if (resp_valid_o && resp_ready_i && resp_o.last) begin
            // Next search starts past the port that just finished
            locked_q <= 1'b0;
            rr_q     <= PORT_W'((int'(grant_q) + 1) % XFCP_N_PORTS);
        end
    end

endmodule

//--- filelist.f
design/xfcp_pkg.sv
design/xfcp_port_demux.sv
design/xfcp_ram_endpoint.sv
design/wb_ram.sv
design/xfcp_resp_arbiter.sv
design/xfcp_ram_hub.sv
tests/xfcp_tb.sv

//--- tests/xfcp_tb.sv
// Testbench for the XFCP RAM hub
// Directed tests for write/read, port isolation, dropped packets,
// back-pressure, concurrent endpoints and address wrap

module xfcp_tb import xfcp_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;
    // Command plus response bytes over all tests, rounded up
    localparam int TEST_BYTES   = 600;
    // Worst case a byte costs 8 cycles with bus access and random ready
    localparam int WATCHDOG_NS  = (TEST_BYTES * 8 + 200) * CLK_PERIOD;

    typedef logic [7:0]           byte_q_t[$];
    typedef logic [WB_DATA_W-1:0] word_q_t[$];

    logic                 clk;
    logic                 rst_n;
    xfcp_beat_t           host_in;
    logic                 host_in_valid;
    logic                 host_in_ready;
    xfcp_beat_t           host_out;
    logic                 host_out_valid;
    logic                 host_out_ready;

    logic [WB_DATA_W-1:0] model [XFCP_N_PORTS][2 ** WB_ADDR_W];
    logic [31:0]          rng_state;
    xfcp_beat_t           rx_q[$];
    int                   errors;
    int                   checks;
    int                   tests_run;

    xfcp_ram_hub UUT (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .host_in_i        (host_in),
        .host_in_valid_i  (host_in_valid),
        .host_in_ready_o  (host_in_ready),
        .host_out_o       (host_out),
        .host_out_valid_o (host_out_valid),
        .host_out_ready_i (host_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    // Xorshift32
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_q_t random_words(input int n);
        word_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(next_rand());
        end
        return q;
    endfunction

    function automatic byte_q_t packet_header(input logic [7:0] port, input logic [7:0] op,
                                              input logic [7:0] addr, input logic [7:0] count);
        byte_q_t q;
        q.push_back(port);
        q.push_back(op);
        q.push_back(addr);
        q.push_back(count);
        return q;
    endfunction

    task automatic check_beat(input xfcp_beat_t got, input xfcp_beat_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %h/%b, expected %h/%b",
                     $time, msg, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic check_word(input logic [WB_DATA_W-1:0] got, input logic [WB_DATA_W-1:0] exp,
                              input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // Entered and left one drive delay after a rising edge
    task automatic send_packet(input byte_q_t bytes);
        for (int i = 0; i < bytes.size(); i++) begin
            host_in.data  = bytes[i];
            host_in.last  = (i == bytes.size() - 1);
            host_in_valid = 1'b1;
            @(negedge clk);
            while (!host_in_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        host_in_valid = 1'b0;
        host_in       = '0;
    endtask

    task automatic receive_packet(input bit random_ready);
        logic [31:0] r;
        bit          done;
        rx_q.delete();
        done = 1'b0;
        while (!done) begin
            r = next_rand();
            host_out_ready = random_ready ? r[0] : 1'b1;
            @(negedge clk);
            if (host_out_valid && host_out_ready) begin
                rx_q.push_back(host_out);
                done = host_out.last;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        host_out_ready = 1'b0;
    endtask

    // Header echo, response opcode, length and read data against the model
    task automatic compare_response(input logic [7:0] port, input logic [7:0] op,
                                    input logic [7:0] addr, input logic [7:0] count);
        int                   data_words;
        int                   exp_len;
        logic [7:0]           hdr [4];
        xfcp_beat_t           exp_beat;
        logic [WB_DATA_W-1:0] word;
        data_words = (op == OP_READ_RESP) ? int'(count) : 0;
        exp_len    = 4 + data_words * BYTES_PER_WORD;
        checks++;
        if (rx_q.size() != exp_len) begin
            errors++;
            $display("response from port %0d has %0d beats where %0d were expected",
                     port, rx_q.size(), exp_len);
            return;
        end
        hdr = '{port, op, addr, count};
        for (int i = 0; i < 4; i++) begin
            exp_beat.data = hdr[i];
            exp_beat.last = (i == 3) && (data_words == 0);
            check_beat(rx_q[i], exp_beat, $sformatf("port %0d header byte %0d", port, i));
        end
        for (int w = 0; w < data_words; w++) begin
            word = {rx_q[4*w+7].data, rx_q[4*w+6].data, rx_q[4*w+5].data, rx_q[4*w+4].data};
            check_word(word, model[port[PORT_W-1:0]][8'(int'(addr) + w)],
                       $sformatf("port %0d read word %0d", port, w));
        end
    endtask

    task automatic write_words(input logic [7:0] port, input logic [7:0] addr,
                               input word_q_t words);
        byte_q_t pkt;
        pkt = packet_header(port, OP_WRITE, addr, 8'(words.size()));
        foreach (words[w]) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                pkt.push_back(words[w][8*b +: 8]);
            end
        end
        send_packet(pkt);
        if (port < XFCP_N_PORTS) begin
            foreach (words[w]) begin
                model[port[PORT_W-1:0]][8'(int'(addr) + w)] = words[w];
            end
            receive_packet(1'b0);
            compare_response(port, OP_WRITE_RESP, addr, 8'(words.size()));
        end
    endtask

    task automatic read_words(input logic [7:0] port, input logic [7:0] addr,
                              input logic [7:0] count, input bit random_ready);
        byte_q_t pkt;
        pkt = packet_header(port, OP_READ, addr, count);
        send_packet(pkt);
        receive_packet(random_ready);
        compare_response(port, OP_READ_RESP, addr, count);
    endtask

    task automatic write_then_read();
        int err0;
        err0 = errors;
        write_words(8'd0, 8'h10, random_words(8));
        read_words(8'd0, 8'h10, 8'd8, 1'b0);
        finish_test("write then read", err0);
    endtask

    task automatic isolate_ports();
        int err0;
        err0 = errors;
        for (int p = 0; p < XFCP_N_PORTS; p++) begin
            write_words(8'(p), 8'h20, random_words(2));
        end
        for (int p = 0; p < XFCP_N_PORTS; p++) begin
            read_words(8'(p), 8'h20, 8'd2, 1'b0);
        end
        finish_test("port isolation", err0);
    endtask

    // Port 7 aliases to port 3 in the low bits, so port 3 is read back
    task automatic drop_unroutable();
        int err0;
        bit seen;
        err0 = errors;
        seen = 1'b0;
        write_words(8'd7, 8'h20, random_words(2));
        repeat (20) begin
            @(negedge clk);
            seen |= host_out_valid;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        checks++;
        if (seen) begin
            errors++;
            $display("a response appeared for a packet sent to port 7");
        end
        read_words(8'd3, 8'h20, 8'd2, 1'b0);
        finish_test("unroutable port", err0);
    endtask

    task automatic apply_backpressure();
        int err0;
        err0 = errors;
        write_words(8'd1, 8'h40, random_words(16));
        read_words(8'd1, 8'h40, 8'd16, 1'b1);
        finish_test("back-pressure", err0);
    endtask

    // Responses may come back in any order, one whole packet each
    task automatic read_concurrently();
        int         err0;
        bit         seen [XFCP_N_PORTS];
        byte_q_t    pkt;
        logic [7:0] port;
        err0 = errors;
        for (int p = 0; p < XFCP_N_PORTS; p++) begin
            pkt = packet_header(8'(p), OP_READ, 8'h20, 8'd2);
            send_packet(pkt);
        end
        for (int n = 0; n < XFCP_N_PORTS; n++) begin
            receive_packet(1'b0);
            port = rx_q[0].data;
            checks++;
            if (port >= XFCP_N_PORTS || seen[port[PORT_W-1:0]]) begin
                errors++;
                $display("response %0d names port %0d, out of range or answered twice", n, port);
            end else begin
                seen[port[PORT_W-1:0]] = 1'b1;
                compare_response(port, OP_READ_RESP, 8'h20, 8'd2);
            end
        end
        finish_test("concurrency", err0);
    endtask

    task automatic cover_edge_cases();
        int err0;
        err0 = errors;
        read_words(8'd2, 8'h20, 8'd0, 1'b0);
        write_words(8'd3, 8'd254, random_words(4));
        read_words(8'd3, 8'd0, 8'd2, 1'b0);
        read_words(8'd3, 8'd254, 8'd4, 1'b0);
        finish_test("edge cases", err0);
    endtask

    initial begin
        rng_state      = 32'd4;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        rst_n          = 1'b0;
        host_in        = '0;
        host_in_valid  = 1'b0;
        host_out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;

        write_then_read();
        isolate_ports();
        drop_unroutable();
        apply_backpressure();
        read_concurrently();
        cover_edge_cases();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
